// ==== Makefile ====
# Verilator build and run of the soc_bus testbench

SRCS := $(shell cat soc_bus.f)
BIN  := obj_dir/Vtb_soc_bus

.PHONY: all run clean

all: run

$(BIN): soc_bus.f $(SRCS)
	verilator --binary --timing -f soc_bus.f --top-module tb_soc_bus -o Vtb_soc_bus

sim.log: $(BIN)
	-$(BIN) > sim.log 2>&1
	cat sim.log

run: sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/axi_clint.sv ====
`timescale 1ns/1ps
// single-beat AXI slave with mtime and mtimecmp, raises the machine timer interrupt
module axi_clint
	import axi_pkg::*;
(
	input  logic    aclk,
	input  logic    rst_n_i,

	input  axi_aw_t s_aw_i,
	input  logic    s_aw_valid_i,
	output logic    s_aw_ready_o,
	input  axi_w_t  s_w_i,
	input  logic    s_w_valid_i,
	output logic    s_w_ready_o,
	output axi_b_t  s_b_o,
	output logic    s_b_valid_o,
	input  logic    s_b_ready_i,
	input  axi_ar_t s_ar_i,
	input  logic    s_ar_valid_i,
	output logic    s_ar_ready_o,
	output axi_r_t  s_r_o,
	output logic    s_r_valid_o,
	input  logic    s_r_ready_i,

	output logic    timer_irq_o
);

	logic [AXI_DATA_WIDTH-1:0] mtime_q;
	logic [AXI_DATA_WIDTH-1:0] mtimecmp_q;
	logic                      cmp_armed_q;
	logic                      r_valid_q;
	axi_r_t                    r_q;
	logic                      aw_pend_q;
	logic [AXI_ADDR_WIDTH-1:0] aw_addr_q;
	logic                      b_valid_q;
	axi_b_t                    b_q;
	logic                      ar_fire;
	logic                      aw_fire;
	logic                      w_fire;
	logic                      wr_mtime;
	logic                      wr_mtimecmp;
	logic [AXI_DATA_WIDTH-1:0] rd_data;

	// registers are one dword each, ignore the byte offset
	function automatic logic reg_hit(input logic [AXI_ADDR_WIDTH-1:0] addr,
			input logic [AXI_ADDR_WIDTH-1:0] ofs);
		return ((addr & ~CLINT_MASK) >> $clog2(AXI_STRB_WIDTH)) ==
			(ofs >> $clog2(AXI_STRB_WIDTH));
	endfunction

	function automatic logic [AXI_DATA_WIDTH-1:0] merge(
			input logic [AXI_DATA_WIDTH-1:0] old_data,
			input axi_w_t w);
		logic [AXI_DATA_WIDTH-1:0] res;
		res = old_data;
		for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
			if (w.strb[i])
				res[i*8 +: 8] = w.data[i*8 +: 8];
		end
		return res;
	endfunction

	assign s_ar_ready_o = !r_valid_q;
	assign s_r_valid_o  = r_valid_q;
	assign s_r_o        = r_q;
	assign s_aw_ready_o = !aw_pend_q && !b_valid_q;
	assign s_w_ready_o  = aw_pend_q;
	assign s_b_valid_o  = b_valid_q;
	assign s_b_o        = b_q;

	assign ar_fire     = s_ar_valid_i && s_ar_ready_o;
	assign aw_fire     = s_aw_valid_i && s_aw_ready_o;
	assign w_fire      = s_w_valid_i && s_w_ready_o;
	assign wr_mtime    = w_fire && reg_hit(aw_addr_q, CLINT_MTIME_OFS);
	assign wr_mtimecmp = w_fire && reg_hit(aw_addr_q, CLINT_MTIMECMP_OFS);

	always_comb begin
		if (reg_hit(s_ar_i.addr, CLINT_MTIME_OFS))
			rd_data = mtime_q;
		else if (reg_hit(s_ar_i.addr, CLINT_MTIMECMP_OFS))
			rd_data = mtimecmp_q;
		else
			rd_data = '0;
	end

	// compare only counts once software has programmed mtimecmp
	assign timer_irq_o = cmp_armed_q && (mtime_q >= mtimecmp_q);

	always_ff @(posedge aclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime_q     <= '0;
			mtimecmp_q  <= '0;
			cmp_armed_q <= 1'b0;
			r_valid_q   <= 1'b0;
			aw_pend_q   <= 1'b0;
			b_valid_q   <= 1'b0;
		end else begin
			// software write wins over the tick
			if (wr_mtime)
				mtime_q <= merge(mtime_q, s_w_i);
			else
				mtime_q <= mtime_q + 1'b1;
			if (wr_mtimecmp) begin
				mtimecmp_q  <= merge(mtimecmp_q, s_w_i);
				cmp_armed_q <= 1'b1;
			end
			if (ar_fire)
				r_valid_q <= 1'b1;
			else if (s_r_ready_i)
				r_valid_q <= 1'b0;
			if (aw_fire)
				aw_pend_q <= 1'b1;
			else if (w_fire)
				aw_pend_q <= 1'b0;
			if (w_fire)
				b_valid_q <= 1'b1;
			else if (s_b_ready_i)
				b_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (ar_fire)
			r_q <= '{data: rd_data, resp: AXI_RESP_OKAY, last: 1'b1, id: s_ar_i.id};
		if (aw_fire) begin
			aw_addr_q <= s_aw_i.addr;
			b_q       <= '{resp: AXI_RESP_OKAY, id: s_aw_i.id};
		end
	end

endmodule

// ==== hdl/axi_pkg.sv ====
// AXI4 widths, address map, channel payload structs and FSM enums shared by every bus block
package axi_pkg;

	localparam int AXI_ADDR_WIDTH  = 32;
	localparam int AXI_DATA_WIDTH  = 64;
	localparam int AXI_STRB_WIDTH  = AXI_DATA_WIDTH / 8;
	localparam int AXI_ID_WIDTH    = 4;
	localparam int AXI_LEN_WIDTH   = 8;
	localparam int AXI_SIZE_WIDTH  = 3;
	localparam int AXI_BURST_WIDTH = 2;
	localparam int AXI_RESP_WIDTH  = 2;

	localparam logic [AXI_RESP_WIDTH-1:0] AXI_RESP_OKAY = 2'b00;

	// CLINT window, 64 KiB at 0x0200_0000
	localparam logic [AXI_ADDR_WIDTH-1:0] CLINT_BASE         = 32'h0200_0000;
	localparam logic [AXI_ADDR_WIDTH-1:0] CLINT_MASK         = 32'hFFFF_0000;
	localparam logic [AXI_ADDR_WIDTH-1:0] CLINT_MTIMECMP_OFS = 32'h0000_4000;
	localparam logic [AXI_ADDR_WIDTH-1:0] CLINT_MTIME_OFS    = 32'h0000_BFF8;

	// address channel, same layout for AW and AR
	typedef struct packed {
		logic [AXI_ADDR_WIDTH-1:0]  addr;
		logic [AXI_ID_WIDTH-1:0]    id;
		logic [AXI_LEN_WIDTH-1:0]   len;
		logic [AXI_SIZE_WIDTH-1:0]  size;
		logic [AXI_BURST_WIDTH-1:0] burst;
	} axi_aw_t;

	typedef axi_aw_t axi_ar_t;

	typedef struct packed {
		logic [AXI_DATA_WIDTH-1:0] data;
		logic [AXI_STRB_WIDTH-1:0] strb;
		logic                      last;
	} axi_w_t;

	typedef struct packed {
		logic [AXI_RESP_WIDTH-1:0] resp;
		logic [AXI_ID_WIDTH-1:0]   id;
	} axi_b_t;

	typedef struct packed {
		logic [AXI_DATA_WIDTH-1:0] data;
		logic [AXI_RESP_WIDTH-1:0] resp;
		logic                      last;
		logic [AXI_ID_WIDTH-1:0]   id;
	} axi_r_t;

	typedef enum logic {
		TGT_MEM,
		TGT_CLINT
	} axi_tgt_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_IFU,
		ARB_LSU
	} arb_state_e;

	typedef enum logic [1:0] {
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

endpackage

// ==== hdl/axi_read_arbiter.sv ====
`timescale 1ns/1ps
// round-robin arbiter merging the fetch and load/store read channels onto one AXI read port
module axi_read_arbiter
	import axi_pkg::*;
(
	input  logic    aclk,
	input  logic    rst_n_i,

	input  axi_ar_t ifu_ar_i,
	input  logic    ifu_ar_valid_i,
	output logic    ifu_ar_ready_o,
	output axi_r_t  ifu_r_o,
	output logic    ifu_r_valid_o,
	input  logic    ifu_r_ready_i,

	input  axi_ar_t lsu_ar_i,
	input  logic    lsu_ar_valid_i,
	output logic    lsu_ar_ready_o,
	output axi_r_t  lsu_r_o,
	output logic    lsu_r_valid_o,
	input  logic    lsu_r_ready_i,

	output axi_ar_t xbar_ar_o,
	output logic    xbar_ar_valid_o,
	input  logic    xbar_ar_ready_i,
	input  axi_r_t  xbar_r_i,
	input  logic    xbar_r_valid_i,
	output logic    xbar_r_ready_o
);

	arb_state_e state_q;
	arb_state_e state_d;
	logic       last_lsu_q;
	logic       ar_sent_q;
	logic       pick_lsu;
	logic       gnt_ifu;
	logic       gnt_lsu;
	logic       ar_fire;
	logic       r_done;

	// on a tie take whoever did not win last time
	assign pick_lsu = lsu_ar_valid_i && (!ifu_ar_valid_i || !last_lsu_q);

	// grant is combinational while idle so AR goes out in the request cycle
	assign gnt_ifu = (state_q == ARB_IFU) ||
		(state_q == ARB_IDLE && ifu_ar_valid_i && !pick_lsu);
	assign gnt_lsu = (state_q == ARB_LSU) || (state_q == ARB_IDLE && pick_lsu);

	assign xbar_ar_o       = gnt_lsu ? lsu_ar_i : ifu_ar_i;
	assign xbar_ar_valid_o = !ar_sent_q &&
		((gnt_ifu && ifu_ar_valid_i) || (gnt_lsu && lsu_ar_valid_i));
	assign ifu_ar_ready_o  = gnt_ifu && !ar_sent_q && xbar_ar_ready_i;
	assign lsu_ar_ready_o  = gnt_lsu && !ar_sent_q && xbar_ar_ready_i;

	// read data only to the granted master
	assign ifu_r_o        = gnt_ifu ? xbar_r_i : '0;
	assign ifu_r_valid_o  = gnt_ifu && xbar_r_valid_i;
	assign lsu_r_o        = gnt_lsu ? xbar_r_i : '0;
	assign lsu_r_valid_o  = gnt_lsu && xbar_r_valid_i;
	assign xbar_r_ready_o = (gnt_ifu && ifu_r_ready_i) || (gnt_lsu && lsu_r_ready_i);

	assign ar_fire = xbar_ar_valid_o && xbar_ar_ready_i;
	assign r_done  = xbar_r_valid_i && xbar_r_ready_o && xbar_r_i.last;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (gnt_lsu)
					state_d = ARB_LSU;
				else if (gnt_ifu)
					state_d = ARB_IFU;
			end
			ARB_IFU, ARB_LSU: begin
				if (r_done)
					state_d = ARB_IDLE;
			end
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge aclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= ARB_IDLE;
			// pretend lsu won last so fetch goes first
			last_lsu_q <= 1'b1;
			ar_sent_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == ARB_IDLE && (gnt_ifu || gnt_lsu))
				last_lsu_q <= gnt_lsu;
			// one read in flight, block further AR until the last beat
			if (r_done)
				ar_sent_q <= 1'b0;
			else if (ar_fire)
				ar_sent_q <= 1'b1;
		end
	end

endmodule

// ==== hdl/axi_xbar.sv ====
`timescale 1ns/1ps
// 1-to-2 AXI crossbar steering the load/store and arbiter traffic to the CLINT or memory port
module axi_xbar
	import axi_pkg::*;
(
	input  logic    aclk,
	input  logic    rst_n_i,

	input  axi_aw_t up_aw_i,
	input  logic    up_aw_valid_i,
	output logic    up_aw_ready_o,
	input  axi_w_t  up_w_i,
	input  logic    up_w_valid_i,
	output logic    up_w_ready_o,
	output axi_b_t  up_b_o,
	output logic    up_b_valid_o,
	input  logic    up_b_ready_i,
	input  axi_ar_t up_ar_i,
	input  logic    up_ar_valid_i,
	output logic    up_ar_ready_o,
	output axi_r_t  up_r_o,
	output logic    up_r_valid_o,
	input  logic    up_r_ready_i,

	output axi_aw_t mem_aw_o,
	output logic    mem_aw_valid_o,
	input  logic    mem_aw_ready_i,
	output axi_w_t  mem_w_o,
	output logic    mem_w_valid_o,
	input  logic    mem_w_ready_i,
	input  axi_b_t  mem_b_i,
	input  logic    mem_b_valid_i,
	output logic    mem_b_ready_o,
	output axi_ar_t mem_ar_o,
	output logic    mem_ar_valid_o,
	input  logic    mem_ar_ready_i,
	input  axi_r_t  mem_r_i,
	input  logic    mem_r_valid_i,
	output logic    mem_r_ready_o,

	output axi_aw_t clint_aw_o,
	output logic    clint_aw_valid_o,
	input  logic    clint_aw_ready_i,
	output axi_w_t  clint_w_o,
	output logic    clint_w_valid_o,
	input  logic    clint_w_ready_i,
	input  axi_b_t  clint_b_i,
	input  logic    clint_b_valid_i,
	output logic    clint_b_ready_o,
	output axi_ar_t clint_ar_o,
	output logic    clint_ar_valid_o,
	input  logic    clint_ar_ready_i,
	input  axi_r_t  clint_r_i,
	input  logic    clint_r_valid_i,
	output logic    clint_r_ready_o
);

	axi_tgt_e  ar_tgt;
	axi_tgt_e  aw_tgt;
	axi_tgt_e  rd_tgt_q;
	axi_tgt_e  wr_tgt_q;
	wr_state_e wr_state_q;

	function automatic axi_tgt_e decode(input logic [AXI_ADDR_WIDTH-1:0] addr);
		if ((addr & CLINT_MASK) == CLINT_BASE)
			return TGT_CLINT;
		return TGT_MEM;
	endfunction

	assign ar_tgt = decode(up_ar_i.addr);
	assign aw_tgt = decode(up_aw_i.addr);

	// read address by decode, read data by the target latched at AR
	assign mem_ar_o         = up_ar_i;
	assign clint_ar_o       = up_ar_i;
	assign mem_ar_valid_o   = up_ar_valid_i && ar_tgt == TGT_MEM;
	assign clint_ar_valid_o = up_ar_valid_i && ar_tgt == TGT_CLINT;
	assign up_ar_ready_o    = (ar_tgt == TGT_CLINT) ? clint_ar_ready_i : mem_ar_ready_i;

	assign up_r_o          = (rd_tgt_q == TGT_CLINT) ? clint_r_i : mem_r_i;
	assign up_r_valid_o    = (rd_tgt_q == TGT_CLINT) ? clint_r_valid_i : mem_r_valid_i;
	assign mem_r_ready_o   = up_r_ready_i && rd_tgt_q == TGT_MEM;
	assign clint_r_ready_o = up_r_ready_i && rd_tgt_q == TGT_CLINT;

	// write address only in WR_ADDR, W held back until AW is through
	assign mem_aw_o         = up_aw_i;
	assign clint_aw_o       = up_aw_i;
	assign mem_aw_valid_o   = up_aw_valid_i && wr_state_q == WR_ADDR && aw_tgt == TGT_MEM;
	assign clint_aw_valid_o = up_aw_valid_i && wr_state_q == WR_ADDR && aw_tgt == TGT_CLINT;
	assign up_aw_ready_o    = wr_state_q == WR_ADDR &&
		((aw_tgt == TGT_CLINT) ? clint_aw_ready_i : mem_aw_ready_i);

	assign mem_w_o         = up_w_i;
	assign clint_w_o       = up_w_i;
	assign mem_w_valid_o   = up_w_valid_i && wr_state_q == WR_DATA && wr_tgt_q == TGT_MEM;
	assign clint_w_valid_o = up_w_valid_i && wr_state_q == WR_DATA && wr_tgt_q == TGT_CLINT;
	assign up_w_ready_o    = wr_state_q == WR_DATA &&
		((wr_tgt_q == TGT_CLINT) ? clint_w_ready_i : mem_w_ready_i);

	assign up_b_o          = (wr_tgt_q == TGT_CLINT) ? clint_b_i : mem_b_i;
	assign up_b_valid_o    = wr_state_q == WR_RESP &&
		((wr_tgt_q == TGT_CLINT) ? clint_b_valid_i : mem_b_valid_i);
	assign mem_b_ready_o   = up_b_ready_i && wr_state_q == WR_RESP && wr_tgt_q == TGT_MEM;
	assign clint_b_ready_o = up_b_ready_i && wr_state_q == WR_RESP && wr_tgt_q == TGT_CLINT;

	always_ff @(posedge aclk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_tgt_q   <= TGT_MEM;
			wr_tgt_q   <= TGT_MEM;
			wr_state_q <= WR_ADDR;
		end else begin
			if (up_ar_valid_i && up_ar_ready_o)
				rd_tgt_q <= ar_tgt;
			case (wr_state_q)
				WR_ADDR: begin
					if (up_aw_valid_i && up_aw_ready_o) begin
						wr_tgt_q   <= aw_tgt;
						wr_state_q <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (up_w_valid_i && up_w_ready_o && up_w_i.last)
						wr_state_q <= WR_RESP;
				end
				WR_RESP: begin
					if (up_b_valid_o && up_b_ready_i)
						wr_state_q <= WR_ADDR;
				end
				default: wr_state_q <= WR_ADDR;
			endcase
		end
	end

endmodule

// ==== hdl/soc_bus.sv ====
`timescale 1ns/1ps
// CPU-side bus top: fetch and load/store ports in, CLINT inside, memory master port out
module soc_bus
	import axi_pkg::*;
(
	input  logic    aclk,
	input  logic    rst_n_i,

	input  axi_ar_t ifu_ar_i,
	input  logic    ifu_ar_valid_i,
	output logic    ifu_ar_ready_o,
	output axi_r_t  ifu_r_o,
	output logic    ifu_r_valid_o,
	input  logic    ifu_r_ready_i,

	input  axi_aw_t lsu_aw_i,
	input  logic    lsu_aw_valid_i,
	output logic    lsu_aw_ready_o,
	input  axi_w_t  lsu_w_i,
	input  logic    lsu_w_valid_i,
	output logic    lsu_w_ready_o,
	output axi_b_t  lsu_b_o,
	output logic    lsu_b_valid_o,
	input  logic    lsu_b_ready_i,
	input  axi_ar_t lsu_ar_i,
	input  logic    lsu_ar_valid_i,
	output logic    lsu_ar_ready_o,
	output axi_r_t  lsu_r_o,
	output logic    lsu_r_valid_o,
	input  logic    lsu_r_ready_i,

	output axi_aw_t mem_aw_o,
	output logic    mem_aw_valid_o,
	input  logic    mem_aw_ready_i,
	output axi_w_t  mem_w_o,
	output logic    mem_w_valid_o,
	input  logic    mem_w_ready_i,
	input  axi_b_t  mem_b_i,
	input  logic    mem_b_valid_i,
	output logic    mem_b_ready_o,
	output axi_ar_t mem_ar_o,
	output logic    mem_ar_valid_o,
	input  logic    mem_ar_ready_i,
	input  axi_r_t  mem_r_i,
	input  logic    mem_r_valid_i,
	output logic    mem_r_ready_o,

	output logic    timer_irq_o
);

	// arbiter to crossbar read path
	axi_ar_t arb_ar;
	logic    arb_ar_valid;
	logic    arb_ar_ready;
	axi_r_t  arb_r;
	logic    arb_r_valid;
	logic    arb_r_ready;

	// crossbar to CLINT
	axi_aw_t clint_aw;
	logic    clint_aw_valid;
	logic    clint_aw_ready;
	axi_w_t  clint_w;
	logic    clint_w_valid;
	logic    clint_w_ready;
	axi_b_t  clint_b;
	logic    clint_b_valid;
	logic    clint_b_ready;
	axi_ar_t clint_ar;
	logic    clint_ar_valid;
	logic    clint_ar_ready;
	axi_r_t  clint_r;
	logic    clint_r_valid;
	logic    clint_r_ready;

	axi_read_arbiter u_read_arbiter (
		.aclk            (aclk),
		.rst_n_i         (rst_n_i),
		.ifu_ar_i        (ifu_ar_i),
		.ifu_ar_valid_i  (ifu_ar_valid_i),
		.ifu_ar_ready_o  (ifu_ar_ready_o),
		.ifu_r_o         (ifu_r_o),
		.ifu_r_valid_o   (ifu_r_valid_o),
		.ifu_r_ready_i   (ifu_r_ready_i),
		.lsu_ar_i        (lsu_ar_i),
		.lsu_ar_valid_i  (lsu_ar_valid_i),
		.lsu_ar_ready_o  (lsu_ar_ready_o),
		.lsu_r_o         (lsu_r_o),
		.lsu_r_valid_o   (lsu_r_valid_o),
		.lsu_r_ready_i   (lsu_r_ready_i),
		.xbar_ar_o       (arb_ar),
		.xbar_ar_valid_o (arb_ar_valid),
		.xbar_ar_ready_i (arb_ar_ready),
		.xbar_r_i        (arb_r),
		.xbar_r_valid_i  (arb_r_valid),
		.xbar_r_ready_o  (arb_r_ready)
	);

	// load/store writes bypass the arbiter
	axi_xbar u_xbar (
		.aclk             (aclk),
		.rst_n_i          (rst_n_i),
		.up_aw_i          (lsu_aw_i),
		.up_aw_valid_i    (lsu_aw_valid_i),
		.up_aw_ready_o    (lsu_aw_ready_o),
		.up_w_i           (lsu_w_i),
		.up_w_valid_i     (lsu_w_valid_i),
		.up_w_ready_o     (lsu_w_ready_o),
		.up_b_o           (lsu_b_o),
		.up_b_valid_o     (lsu_b_valid_o),
		.up_b_ready_i     (lsu_b_ready_i),
		.up_ar_i          (arb_ar),
		.up_ar_valid_i    (arb_ar_valid),
		.up_ar_ready_o    (arb_ar_ready),
		.up_r_o           (arb_r),
		.up_r_valid_o     (arb_r_valid),
		.up_r_ready_i     (arb_r_ready),
		.mem_aw_o         (mem_aw_o),
		.mem_aw_valid_o   (mem_aw_valid_o),
		.mem_aw_ready_i   (mem_aw_ready_i),
		.mem_w_o          (mem_w_o),
		.mem_w_valid_o    (mem_w_valid_o),
		.mem_w_ready_i    (mem_w_ready_i),
		.mem_b_i          (mem_b_i),
		.mem_b_valid_i    (mem_b_valid_i),
		.mem_b_ready_o    (mem_b_ready_o),
		.mem_ar_o         (mem_ar_o),
		.mem_ar_valid_o   (mem_ar_valid_o),
		.mem_ar_ready_i   (mem_ar_ready_i),
		.mem_r_i          (mem_r_i),
		.mem_r_valid_i    (mem_r_valid_i),
		.mem_r_ready_o    (mem_r_ready_o),
		.clint_aw_o       (clint_aw),
		.clint_aw_valid_o (clint_aw_valid),
		.clint_aw_ready_i (clint_aw_ready),
		.clint_w_o        (clint_w),
		.clint_w_valid_o  (clint_w_valid),
		.clint_w_ready_i  (clint_w_ready),
		.clint_b_i        (clint_b),
		.clint_b_valid_i  (clint_b_valid),
		.clint_b_ready_o  (clint_b_ready),
		.clint_ar_o       (clint_ar),
		.clint_ar_valid_o (clint_ar_valid),
		.clint_ar_ready_i (clint_ar_ready),
		.clint_r_i        (clint_r),
		.clint_r_valid_i  (clint_r_valid),
		.clint_r_ready_o  (clint_r_ready)
	);

	axi_clint u_clint (
		.aclk         (aclk),
		.rst_n_i      (rst_n_i),
		.s_aw_i       (clint_aw),
		.s_aw_valid_i (clint_aw_valid),
		.s_aw_ready_o (clint_aw_ready),
		.s_w_i        (clint_w),
		.s_w_valid_i  (clint_w_valid),
		.s_w_ready_o  (clint_w_ready),
		.s_b_o        (clint_b),
		.s_b_valid_o  (clint_b_valid),
		.s_b_ready_i  (clint_b_ready),
		.s_ar_i       (clint_ar),
		.s_ar_valid_i (clint_ar_valid),
		.s_ar_ready_o (clint_ar_ready),
		.s_r_o        (clint_r),
		.s_r_valid_o  (clint_r_valid),
		.s_r_ready_i  (clint_r_ready),
		.timer_irq_o  (timer_irq_o)
	);

endmodule

// ==== soc_bus.f ====
hdl/axi_pkg.sv
hdl/axi_read_arbiter.sv
hdl/axi_xbar.sv
hdl/axi_clint.sv
hdl/soc_bus.sv
test/axi_mem_model.sv
test/tb_soc_bus.sv

// ==== test/axi_mem_model.sv ====
// AXI memory slave for the testbench with random ready and latency, unwritten words read as address XOR key
`timescale 1ns/1ps
module axi_mem_model
	import axi_pkg::*;
#(
	parameter logic [AXI_DATA_WIDTH-1:0] FILL_KEY = '0
) (
	input  logic    aclk,
	input  logic    rst_n_i,
	input  axi_aw_t aw_i,
	input  logic    aw_valid_i,
	output logic    aw_ready_o,
	input  axi_w_t  w_i,
	input  logic    w_valid_i,
	output logic    w_ready_o,
	output axi_b_t  b_o,
	output logic    b_valid_o,
	input  logic    b_ready_i,
	input  axi_ar_t ar_i,
	input  logic    ar_valid_i,
	output logic    ar_ready_o,
	output axi_r_t  r_o,
	output logic    r_valid_o,
	input  logic    r_ready_i
);

	// sparse shadow, one entry per written dword
	logic [AXI_DATA_WIDTH-1:0] store [logic [AXI_ADDR_WIDTH-4:0]];
	axi_ar_t                   ar_q;
	axi_aw_t                   aw_q;
	axi_w_t                    w_q;
	logic                      ar_go;
	logic                      r_go;
	logic                      aw_go;
	logic                      w_go;
	logic                      b_go;
	logic [AXI_ADDR_WIDTH-1:0] rd_addr;
	logic [AXI_ADDR_WIDTH-1:0] wr_addr;
	logic [AXI_DATA_WIDTH-1:0] word;
	logic                      wr_active;
	logic                      b_pend;
	int                        rd_left;
	int                        rd_wait;
	int                        b_wait;

	function automatic logic [AXI_DATA_WIDTH-1:0] read_word(input logic [AXI_ADDR_WIDTH-1:0] a);
		if (store.exists(a[AXI_ADDR_WIDTH-1:3]))
			return store[a[AXI_ADDR_WIDTH-1:3]];
		return {~a, a} ^ FILL_KEY;
	endfunction

	initial begin
		aw_ready_o = 1'b0;
		w_ready_o  = 1'b0;
		b_valid_o  = 1'b0;
		b_o        = '0;
		ar_ready_o = 1'b0;
		r_valid_o  = 1'b0;
		r_o        = '0;
		wr_active  = 1'b0;
		b_pend     = 1'b0;
		rd_left    = 0;
		rd_wait    = 0;
		b_wait     = 0;
		forever begin
			// handshakes judged mid-cycle where every signal has settled
			@(negedge aclk);
			ar_go = ar_valid_i && ar_ready_o;
			r_go  = r_valid_o && r_ready_i;
			aw_go = aw_valid_i && aw_ready_o;
			w_go  = w_valid_i && w_ready_o;
			b_go  = b_valid_o && b_ready_i;
			if (ar_go)
				ar_q = ar_i;
			if (aw_go)
				aw_q = aw_i;
			if (w_go)
				w_q = w_i;
			@(posedge aclk);
			#1;
			if (rst_n_i) begin
				if (ar_go) begin
					rd_addr = ar_q.addr;
					rd_left = int'(ar_q.len) + 1;
					rd_wait = $urandom_range(3, 0);
				end
				if (r_go) begin
					r_valid_o = 1'b0;
					rd_addr   = rd_addr + 32'd8;
					rd_left--;
					rd_wait   = $urandom_range(1, 0);
				end
				if (rd_left > 0 && !r_valid_o) begin
					if (rd_wait == 0) begin
						r_o = '{data: read_word(rd_addr), resp: AXI_RESP_OKAY,
							last: rd_left == 1, id: ar_q.id};
						r_valid_o = 1'b1;
					end else begin
						rd_wait--;
					end
				end
				ar_ready_o = (rd_left == 0) && 1'($urandom);
				if (aw_go) begin
					wr_addr   = aw_q.addr;
					wr_active = 1'b1;
				end
				if (w_go) begin
					word = read_word(wr_addr);
					for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
						if (w_q.strb[i])
							word[i*8 +: 8] = w_q.data[i*8 +: 8];
					end
					store[wr_addr[AXI_ADDR_WIDTH-1:3]] = word;
					wr_addr = wr_addr + 32'd8;
					if (w_q.last) begin
						wr_active = 1'b0;
						b_pend    = 1'b1;
						b_wait    = $urandom_range(3, 0);
					end
				end
				if (b_go) begin
					b_valid_o = 1'b0;
					b_pend    = 1'b0;
				end
				if (b_pend && !b_valid_o) begin
					if (b_wait == 0) begin
						b_o       = '{resp: AXI_RESP_OKAY, id: aw_q.id};
						b_valid_o = 1'b1;
					end else begin
						b_wait--;
					end
				end
				w_ready_o  = wr_active && 1'($urandom);
				aw_ready_o = !wr_active && !b_pend && 1'($urandom);
			end
		end
	end

endmodule

// ==== test/tb_soc_bus.sv ====
// testbench driving fetch and load/store traffic through soc_bus against a memory model and the CLINT
`timescale 1ns/1ps
module tb_soc_bus;
	import axi_pkg::*;

	localparam logic [63:0] FILL_KEY = 64'h3c5a_96f0_0ff0_a55a;
	localparam logic [31:0] MEM_BASE = 32'h8000_0000;
	localparam logic [31:0] CMP_ADDR = CLINT_BASE + CLINT_MTIMECMP_OFS;
	localparam logic [31:0] MTIME_ADDR = CLINT_BASE + CLINT_MTIME_OFS;
	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic   chk;
		axi_r_t r;
	} exp_beat_t;

	typedef enum {
		IFU_AR_RDY,
		LSU_AR_RDY,
		LSU_AW_RDY,
		LSU_W_RDY,
		LSU_B_FIRE,
		IRQ_HIGH,
		IRQ_LOW
	} probe_e;

	logic    aclk = 1'b0;
	logic    rst_n_i;
	axi_ar_t ifu_ar_i;
	logic    ifu_ar_valid_i;
	logic    ifu_ar_ready_o;
	axi_r_t  ifu_r_o;
	logic    ifu_r_valid_o;
	logic    ifu_r_ready_i;
	axi_aw_t lsu_aw_i;
	logic    lsu_aw_valid_i;
	logic    lsu_aw_ready_o;
	axi_w_t  lsu_w_i;
	logic    lsu_w_valid_i;
	logic    lsu_w_ready_o;
	axi_b_t  lsu_b_o;
	logic    lsu_b_valid_o;
	logic    lsu_b_ready_i;
	axi_ar_t lsu_ar_i;
	logic    lsu_ar_valid_i;
	logic    lsu_ar_ready_o;
	axi_r_t  lsu_r_o;
	logic    lsu_r_valid_o;
	logic    lsu_r_ready_i;
	axi_aw_t mem_aw_o;
	logic    mem_aw_valid_o;
	logic    mem_aw_ready_i;
	axi_w_t  mem_w_o;
	logic    mem_w_valid_o;
	logic    mem_w_ready_i;
	axi_b_t  mem_b_i;
	logic    mem_b_valid_i;
	logic    mem_b_ready_o;
	axi_ar_t mem_ar_o;
	logic    mem_ar_valid_o;
	logic    mem_ar_ready_i;
	axi_r_t  mem_r_i;
	logic    mem_r_valid_i;
	logic    mem_r_ready_o;
	logic    timer_irq_o;

	// expected read beats per master
	exp_beat_t   ifu_q[$];
	exp_beat_t   lsu_q[$];
	logic [63:0] shadow [logic [28:0]];
	logic [63:0] cmp_model;
	logic [63:0] lsu_last_data;

	soc_bus u_dut (.*);

	axi_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
		.aclk       (aclk),
		.rst_n_i    (rst_n_i),
		.aw_i       (mem_aw_o),
		.aw_valid_i (mem_aw_valid_o),
		.aw_ready_o (mem_aw_ready_i),
		.w_i        (mem_w_o),
		.w_valid_i  (mem_w_valid_o),
		.w_ready_o  (mem_w_ready_i),
		.b_o        (mem_b_i),
		.b_valid_o  (mem_b_valid_i),
		.b_ready_i  (mem_b_ready_o),
		.ar_i       (mem_ar_o),
		.ar_valid_i (mem_ar_valid_o),
		.ar_ready_o (mem_ar_ready_i),
		.r_o        (mem_r_i),
		.r_valid_o  (mem_r_valid_i),
		.r_ready_i  (mem_r_ready_o)
	);

	always #50 aclk = ~aclk;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic probe(input probe_e what);
		case (what)
			IFU_AR_RDY: return ifu_ar_ready_o;
			LSU_AR_RDY: return lsu_ar_ready_o;
			LSU_AW_RDY: return lsu_aw_ready_o;
			LSU_W_RDY:  return lsu_w_ready_o;
			LSU_B_FIRE: return lsu_b_valid_o && lsu_b_ready_i;
			IRQ_HIGH:   return timer_irq_o;
			default:    return !timer_irq_o;
		endcase
	endfunction

	// returns mid-cycle once the condition holds
	// a transfer then lands on the next rising edge
	task automatic wait_for(input probe_e what, input string desc);
		int n;
		n = 0;
		@(negedge aclk);
		while (!probe(what)) begin
			n++;
			if (n > TIMEOUT) begin
				$display("timeout waiting for %s", desc);
				abort_run();
			end
			@(negedge aclk);
		end
	endtask

	// polled just after the rising edge so the scoreboard has already popped
	task automatic wait_drained(input bit lsu);
		int n;
		n = 0;
		while ((lsu ? lsu_q.size() : ifu_q.size()) != 0) begin
			n++;
			if (n > TIMEOUT) begin
				$display("timeout waiting for all %s read beats", lsu ? "lsu" : "ifu");
				abort_run();
			end
			@(posedge aclk);
			#1;
		end
	endtask

	function automatic logic [63:0] apply_strb(input logic [63:0] old, input logic [63:0] data,
			input logic [7:0] strb);
		logic [63:0] mask;
		for (int i = 0; i < 8; i++)
			mask[i*8 +: 8] = {8{strb[i]}};
		return (old & ~mask) | (data & mask);
	endfunction

	function automatic logic [63:0] expect_word(input logic [31:0] a);
		if ((a & CLINT_MASK) == CLINT_BASE)
			return cmp_model;
		if (shadow.exists(a[31:3]))
			return shadow[a[31:3]];
		return {~a, a} ^ FILL_KEY;
	endfunction

	function automatic logic [31:0] random_addr();
		return MEM_BASE + {23'd0, 6'($urandom), 3'd0};
	endfunction

	task automatic score_beat(input bit lsu, input axi_r_t r);
		exp_beat_t e;
		string     port;
		port = lsu ? "lsu" : "ifu";
		if ((lsu ? lsu_q.size() : ifu_q.size()) == 0) begin
			$display("read data reached the %s port with no read outstanding there", port);
			abort_run();
		end
		if (lsu)
			e = lsu_q.pop_front();
		else
			e = ifu_q.pop_front();
		if (e.chk)
			compare({port, "_r_o.data"}, r.data, e.r.data);
		compare({port, "_r_o.resp"}, 64'(r.resp), 64'(e.r.resp));
		compare({port, "_r_o.last"}, 64'(r.last), 64'(e.r.last));
		compare({port, "_r_o.id"}, 64'(r.id), 64'(e.r.id));
		if (lsu)
			lsu_last_data = r.data;
	endtask

	always @(negedge aclk) begin
		if (ifu_r_valid_o && ifu_r_ready_i)
			score_beat(1'b0, ifu_r_o);
		if (lsu_r_valid_o && lsu_r_ready_i)
			score_beat(1'b1, lsu_r_o);
	end

	task automatic read_burst(input bit lsu, input logic [31:0] addr, input logic [3:0] id,
			input int len, input bit chk);
		axi_ar_t   ar;
		exp_beat_t e;
		ar = '{addr: addr, id: id, len: 8'(len), size: 3'd3, burst: 2'b01};
		for (int i = 0; i <= len; i++) begin
			e.chk = chk;
			e.r   = '{data: expect_word(addr + 32'(i * 8)), resp: AXI_RESP_OKAY,
				last: i == len, id: id};
			if (lsu)
				lsu_q.push_back(e);
			else
				ifu_q.push_back(e);
		end
		if (lsu) begin
			lsu_ar_i       = ar;
			lsu_ar_valid_i = 1'b1;
		end else begin
			ifu_ar_i       = ar;
			ifu_ar_valid_i = 1'b1;
		end
		wait_for(lsu ? LSU_AR_RDY : IFU_AR_RDY, "AR ready");
		// granted AR reaches the memory port unchanged unless the CLINT is addressed
		if ((addr & CLINT_MASK) == CLINT_BASE) begin
			compare("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'h0);
		end else begin
			compare("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'h1);
			compare("mem_ar_o", 64'(mem_ar_o), 64'(ar));
		end
		@(posedge aclk);
		#1;
		if (lsu)
			lsu_ar_valid_i = 1'b0;
		else
			ifu_ar_valid_i = 1'b0;
		wait_drained(lsu);
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
			input logic [7:0] strb, input logic [3:0] id);
		axi_aw_t aw;
		aw             = '{addr: addr, id: id, len: 8'd0, size: 3'd3, burst: 2'b01};
		lsu_aw_i       = aw;
		lsu_aw_valid_i = 1'b1;
		wait_for(LSU_AW_RDY, "lsu AW ready");
		if ((addr & CLINT_MASK) == CLINT_BASE) begin
			compare("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'h0);
		end else begin
			compare("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'h1);
			compare("mem_aw_o", 64'(mem_aw_o), 64'(aw));
		end
		@(posedge aclk);
		#1;
		lsu_aw_valid_i = 1'b0;
		lsu_w_i        = '{data: data, strb: strb, last: 1'b1};
		lsu_w_valid_i  = 1'b1;
		wait_for(LSU_W_RDY, "lsu W ready");
		@(posedge aclk);
		#1;
		lsu_w_valid_i = 1'b0;
		wait_for(LSU_B_FIRE, "lsu write response");
		compare("lsu_b_o.resp", 64'(lsu_b_o.resp), 64'(AXI_RESP_OKAY));
		compare("lsu_b_o.id", 64'(lsu_b_o.id), 64'(id));
		if ((addr & CLINT_MASK) == CLINT_BASE)
			cmp_model = apply_strb(cmp_model, data, strb);
		else
			shadow[addr[31:3]] = apply_strb(expect_word(addr), data, strb);
		@(posedge aclk);
		#1;
	endtask

	// master back-pressure on R and B
	initial begin
		ifu_r_ready_i = 1'b0;
		lsu_r_ready_i = 1'b0;
		lsu_b_ready_i = 1'b0;
		forever begin
			@(posedge aclk);
			#1;
			ifu_r_ready_i = 1'($urandom);
			lsu_r_ready_i = 1'($urandom);
			lsu_b_ready_i = 1'($urandom);
		end
	end

	initial begin
		logic [63:0] t0;
		logic [31:0] a;
		void'($urandom(32'h5c949adb));
		cmp_model      = '0;
		lsu_last_data  = '0;
		rst_n_i        = 1'b0;
		ifu_ar_i       = '0;
		ifu_ar_valid_i = 1'b0;
		lsu_aw_i       = '0;
		lsu_aw_valid_i = 1'b0;
		lsu_w_i        = '0;
		lsu_w_valid_i  = 1'b0;
		lsu_ar_i       = '0;
		lsu_ar_valid_i = 1'b0;
		repeat (2) @(posedge aclk);
		#1;
		rst_n_i = 1'b1;
		compare("ifu_r_valid_o", 64'(ifu_r_valid_o), 64'h0);
		compare("lsu_r_valid_o", 64'(lsu_r_valid_o), 64'h0);
		compare("lsu_b_valid_o", 64'(lsu_b_valid_o), 64'h0);
		compare("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'h0);
		compare("mem_w_valid_o", 64'(mem_w_valid_o), 64'h0);
		compare("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'h0);
		compare("timer_irq_o", 64'(timer_irq_o), 64'h0);
		// one master at a time with bursts of 1 to 4 beats
		for (int i = 0; i < 8; i++)
			read_burst(i[0], random_addr(), 4'(i), $urandom_range(3, 0), 1'b1);
		for (int i = 0; i < 12; i++) begin
			a = random_addr();
			write_word(a, {$urandom, $urandom}, 8'($urandom), 4'($urandom));
			read_burst(1'b1, a, 4'($urandom), 0, 1'b1);
		end
		// both masters at once so the arbiter has to alternate
		fork
			for (int i = 0; i < 16; i++)
				read_burst(1'b0, random_addr(), 4'($urandom), $urandom_range(3, 0), 1'b1);
			for (int i = 0; i < 16; i++)
				read_burst(1'b1, random_addr(), 4'($urandom), $urandom_range(3, 0), 1'b1);
		join
		for (int i = 0; i < 4; i++) begin
			write_word(CMP_ADDR, {$urandom, $urandom}, 8'($urandom), 4'($urandom));
			read_burst(1'b1, CMP_ADDR, 4'($urandom), 0, 1'b1);
		end
		read_burst(1'b1, MTIME_ADDR, 4'h1, 0, 1'b0);
		t0 = lsu_last_data;
		read_burst(1'b1, MTIME_ADDR, 4'h2, 0, 1'b0);
		compare("mtime increasing", 64'(lsu_last_data > t0), 64'h1);
		// compare point a little ahead of the current time
		read_burst(1'b1, MTIME_ADDR, 4'h3, 0, 1'b0);
		write_word(CMP_ADDR, lsu_last_data + 64'd100, 8'hFF, 4'h4);
		compare("timer_irq_o", 64'(timer_irq_o), 64'h0);
		wait_for(IRQ_HIGH, "timer_irq_o to rise");
		@(posedge aclk);
		#1;
		write_word(CMP_ADDR, '1, 8'hFF, 4'h5);
		wait_for(IRQ_LOW, "timer_irq_o to fall");
		$display("All tests passed");
		$finish;
	end

endmodule
